// File: hw/cachePkg.sv
// Shared sizes and types for the direct-mapped write-back cache
// Imported by every block that touches addresses, lines or the line bus

package cachePkg;

  localparam int ADR_BITS    = 16;  // Word address width
  localparam int WORD_BITS   = 32;  // Data word width
  localparam int LINE_WORDS  = 4;   // Words per line
  localparam int SETS        = 16;  // Direct mapped, one line per set
  localparam int OFFSET_BITS = 2;   // Word within line
  localparam int SET_BITS    = 4;   // Set index
  localparam int TAG_BITS    = 10;  // Remaining upper bits

  // Address fields, MSB first
  typedef struct packed {
    logic [TAG_BITS-1:0]    tag;
    logic [SET_BITS-1:0]    set;
    logic [OFFSET_BITS-1:0] offset;
  } adrFieldsT;

  // One address word, seen raw or split into fields
  typedef union packed {
    logic [ADR_BITS-1:0] word;
    adrFieldsT           f;
  } cacheAdrT;

  typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] lineT;  // Full line, word 0 in the low bits

  // Line request from the controller to the transfer engine
  typedef struct packed {
    logic                         read;       // Line fetch
    logic                         write;      // Line writeback
    logic [TAG_BITS+SET_BITS-1:0] lineAdr;    // Tag and set of the line
    lineT                         writeLine;  // Data for a writeback
  } busReqT;

endpackage

// File: hw/cacheFsm.sv
// Cache controller state machine
// Decodes hits, misses, writeback, flush and invalidate into array and bus controls

module cacheFsm (
  input  logic       clk,
  input  logic       rst,
  // CPU side
  input  logic [1:0] cacheRW,          // [1] read, [0] write
  input  logic       flushCache,       // Level, held until stall drops
  input  logic       invalidateCache,  // One-cycle pulse
  output logic       stall,
  // From the arrays
  input  logic       hit,
  input  logic       lineDirty,        // Selected line valid and dirty
  input  logic       flushDone,        // Flush counter on its last set
  // Line bus
  input  logic       busAck,
  output logic [1:0] busRW,            // [1] line fetch, [0] line writeback
  // Array controls
  output logic       setValid,
  output logic       setDirty,
  output logic       clearDirty,
  output logic       invalidateAll,
  output logic       selFlush,
  output logic       flushCntEn,
  output logic       flushCntRst,
  output logic       lineWrite,
  output logic       wordWrite,
  output logic       selFetchBuffer
);

  typedef enum logic [2:0] {
    stateReady,
    stateFetch,
    stateWriteback,
    stateWriteLine,
    stateReadHold,       // One cycle for the refilled array to settle before the hit
    stateFlush,
    stateFlushWriteback
  } stateT;

  stateT state, nextState;

  logic anyAccess;
  logic anyMiss;
  logic missGo;      // Miss that actually starts a line transfer
  logic replay;      // Request blocked by an invalidate
  logic updateHit;   // Store hit that writes the array

  assign anyAccess = |cacheRW;
  assign anyMiss   = anyAccess & ~hit & ~invalidateCache;
  assign missGo    = anyMiss & ~flushCache;                  // Flush wins over a miss
  assign replay    = anyAccess & invalidateCache;            // Retried after the valid bits clear
  assign updateHit = cacheRW[0] & hit & ~invalidateCache & ~flushCache;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) state <= stateReady;
    else     state <= nextState;
  end

  always_comb begin
    nextState = stateReady;
    case (state)
      stateReady: begin
        if (invalidateCache)            nextState = stateReady;       // Invalidate first
        else if (flushCache)            nextState = stateFlush;
        else if (anyMiss && !lineDirty) nextState = stateFetch;
        else if (anyMiss)               nextState = stateWriteback;   // Evict dirty victim first
        else                            nextState = stateReady;
      end
      stateFetch:     nextState = busAck ? stateWriteLine : stateFetch;
      stateWriteback: nextState = busAck ? stateFetch : stateWriteback;
      stateWriteLine: nextState = stateReadHold;
      stateReadHold:  nextState = stateReady;
      stateFlush: begin
        if (lineDirty)      nextState = stateFlushWriteback;
        else if (flushDone) nextState = stateReadHold;
        else                nextState = stateFlush;                   // Next set
      end
      stateFlushWriteback: begin
        if (busAck && !flushDone) nextState = stateFlush;
        else if (busAck)          nextState = stateReadHold;
        else                      nextState = stateFlushWriteback;
      end
      default: nextState = stateReady;
    endcase
  end

  ////////////////////
  // CPU stall
  ////////////////////

  // A finished flush is released in readHold so the CPU drops flushCache
  // before ready; a pending access is held for its hit in ready
  assign stall = (state == stateReady & (flushCache | anyMiss | replay)) |
                 (state == stateFetch) |
                 (state == stateWriteback) |
                 (state == stateWriteLine) |
                 (state == stateReadHold & anyAccess) |
                 (state == stateFlush) |
                 (state == stateFlushWriteback);

  ////////////////////
  // Array controls
  ////////////////////

  assign invalidateAll  = (state == stateReady) & invalidateCache;
  assign setValid       = (state == stateWriteLine);             // New tag goes in with the line
  assign lineWrite      = (state == stateWriteLine);
  assign wordWrite      = (state == stateReady) & updateHit;
  assign setDirty       = (state == stateReady) & updateHit;
  assign clearDirty     = (state == stateWriteLine) |            // Fresh line is clean
                          (state == stateFlushWriteback & busAck);
  assign selFetchBuffer = (state == stateWriteLine) | (state == stateReadHold);

  // Flush walk
  assign selFlush    = (state == stateReady & flushCache) |
                       (state == stateFlush) |
                       (state == stateFlushWriteback);
  assign flushCntEn  = (state == stateFlush & ~lineDirty) |
                       (state == stateFlushWriteback & busAck);
  assign flushCntRst = (state == stateFlush & ~lineDirty & flushDone) |
                       (state == stateFlushWriteback & busAck & flushDone);

  ////////////////////
  // Line bus strobes
  ////////////////////

  // Held through the busAck cycle, the engine ignores that cycle
  assign busRW[1] = (state == stateReady & missGo & ~lineDirty) |
                    (state == stateFetch);
  assign busRW[0] = (state == stateReady & missGo & lineDirty) |
                    (state == stateWriteback) |
                    (state == stateFlushWriteback);

endmodule

// File: hw/tagArray.sv
// Tag, valid and dirty storage for the sets of the cache
// Also holds the flush set counter and selects the set in use

module tagArray import cachePkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  cacheAdrT            adr,
  input  logic                setValid,
  input  logic                setDirty,
  input  logic                clearDirty,
  input  logic                invalidateAll,
  input  logic                selFlush,      // Set comes from the flush counter
  input  logic                flushCntEn,
  input  logic                flushCntRst,
  output logic                hit,
  output logic                lineDirty,
  output logic                flushDone,
  output logic [SET_BITS-1:0] index,
  output logic [TAG_BITS-1:0] victimTag      // Stored tag of the selected set
);

  logic [TAG_BITS-1:0] tags [SETS];
  logic [SETS-1:0]     valid;
  logic [SETS-1:0]     dirty;
  logic [SET_BITS-1:0] flushCnt;

  assign index = selFlush ? flushCnt : adr.f.set;

  // Async lookup
  assign victimTag = tags[index];
  assign hit       = valid[index] & (tags[index] == adr.f.tag);
  assign lineDirty = valid[index] & dirty[index];  // Invalid lines never need writeback
  assign flushDone = selFlush & (flushCnt == SET_BITS'(SETS - 1));

  always_ff @(posedge clk) begin
    if (setValid) tags[index] <= adr.f.tag;  // Refill takes the requested tag
  end

  always_ff @(posedge clk) begin
    if (rst || invalidateAll) valid <= '0;
    else if (setValid)        valid[index] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst)             dirty <= '0;
    else if (setDirty)   dirty[index] <= 1'b1;   // Store hit
    else if (clearDirty) dirty[index] <= 1'b0;   // Refill or flush writeback done
  end

  ////////////////////
  // Flush counter
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst || flushCntRst) flushCnt <= '0;
    else if (flushCntEn)    flushCnt <= flushCnt + SET_BITS'(1);
  end

endmodule

// File: hw/dataArray.sv
// Line data storage of the cache
// Whole-line refill from the fetch buffer, single-word store hits, async read

module dataArray import cachePkg::*; (
  input  logic                   clk,
  input  logic [SET_BITS-1:0]    index,
  input  logic [OFFSET_BITS-1:0] offset,
  input  logic                   lineWrite,   // Refill
  input  lineT                   fetchLine,
  input  logic                   wordWrite,   // Store hit
  input  logic [WORD_BITS-1:0]   writeData,
  output lineT                   line,        // Victim line for writeback
  output logic [WORD_BITS-1:0]   readWord
);

  lineT lines [SETS];

  always_ff @(posedge clk) begin
    if (lineWrite) begin
      lines[index] <= fetchLine;
    end else if (wordWrite) begin
      lines[index][offset] <= writeData;  // Full word, no byte enables
    end
  end

  // Combinational read of the selected set
  assign line     = lines[index];
  assign readWord = line[offset];

endmodule

// File: hw/lineBus.sv
// Line transfer engine between the cache and the word-wide memory port
// One line request becomes four beats, each held until memAck

module lineBus import cachePkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  busReqT                req,
  input  logic [WORD_BITS-1:0]  memReadData,
  input  logic                  memAck,        // One-cycle pulse per beat
  output logic                  busAck,        // Line done, one cycle after the last memAck
  output lineT                  fetchLine,     // Valid from busAck until the next fetch
  output logic                  memRead,
  output logic                  memWrite,
  output logic [ADR_BITS-1:0]   memAdr,
  output logic [WORD_BITS-1:0]  memWriteData
);

  logic                   active;
  logic                   writeDir;   // Direction of the running transfer
  logic [OFFSET_BITS-1:0] beat;
  logic                   start;
  logic                   lastBeat;

  // The busAck cycle still shows the finished request, so it never starts one
  assign start    = ~active & ~busAck & (req.read | req.write);
  assign lastBeat = (beat == OFFSET_BITS'(LINE_WORDS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      writeDir <= 1'b0;
      beat     <= '0;
      busAck   <= 1'b0;
    end else begin
      busAck <= 1'b0;
      if (start) begin
        active   <= 1'b1;
        writeDir <= req.write;
        beat     <= '0;
      end else if (active && memAck) begin
        beat <= beat + OFFSET_BITS'(1);
        if (lastBeat) begin
          active <= 1'b0;
          busAck <= 1'b1;
        end
      end
    end
  end

  // Fetch buffer, one word per acknowledged read beat
  always_ff @(posedge clk) begin
    if (active && memAck && !writeDir) fetchLine[beat] <= memReadData;
  end

  assign memRead      = active & ~writeDir;
  assign memWrite     = active & writeDir;
  assign memAdr       = {req.lineAdr, beat};     // Line address plus beat as word offset
  assign memWriteData = req.writeLine[beat];

endmodule

// File: hw/cacheTop.sv
// Top level of the write-back data cache
// CPU word port on one side, word-wide memory port with acknowledges on the other

module cacheTop import cachePkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [1:0]           cacheRW,          // [1] read, [0] write
  input  cacheAdrT             adr,
  input  logic [WORD_BITS-1:0] writeData,
  input  logic                 flushCache,
  input  logic                 invalidateCache,
  output logic [WORD_BITS-1:0] readData,
  output logic                 stall,
  output logic                 memRead,
  output logic                 memWrite,
  output logic [ADR_BITS-1:0]  memAdr,
  output logic [WORD_BITS-1:0] memWriteData,
  input  logic [WORD_BITS-1:0] memReadData,
  input  logic                 memAck
);

  logic [1:0]           busRW;
  logic                 busAck;
  logic                 hit, lineDirty, flushDone;
  logic                 setValid, setDirty, clearDirty, invalidateAll;
  logic                 selFlush, flushCntEn, flushCntRst;
  logic                 lineWrite, wordWrite, selFetchBuffer;
  logic [SET_BITS-1:0]  index;
  logic [TAG_BITS-1:0]  victimTag;
  logic [WORD_BITS-1:0] readWord;
  lineT                 line, fetchLine;
  busReqT               busReq;

  cacheFsm u_fsm (
    .clk, .rst, .cacheRW, .flushCache, .invalidateCache, .stall,
    .hit, .lineDirty, .flushDone, .busAck, .busRW,
    .setValid, .setDirty, .clearDirty, .invalidateAll, .selFlush,
    .flushCntEn, .flushCntRst, .lineWrite, .wordWrite, .selFetchBuffer
  );

  tagArray u_tags (
    .clk, .rst, .adr, .setValid, .setDirty, .clearDirty, .invalidateAll,
    .selFlush, .flushCntEn, .flushCntRst,
    .hit, .lineDirty, .flushDone, .index, .victimTag
  );

  dataArray u_data (
    .clk, .index, .offset(adr.f.offset), .lineWrite, .fetchLine,
    .wordWrite, .writeData, .line, .readWord
  );

  // Writeback goes to the victim's line, a fetch to the requested one
  assign busReq.read      = busRW[1];
  assign busReq.write     = busRW[0];
  assign busReq.lineAdr   = {(busRW[0] ? victimTag : adr.f.tag), index};
  assign busReq.writeLine = line;

  lineBus u_bus (
    .clk, .rst, .req(busReq), .memReadData, .memAck, .busAck, .fetchLine,
    .memRead, .memWrite, .memAdr, .memWriteData
  );

  // Bypass to the just-fetched line while the refill settles
  assign readData = selFetchBuffer ? fetchLine[adr.f.offset] : readWord;

endmodule

// File: verification/tbClock.sv
// Clock and reset source for the cache testbench
// 100 ns clock, reset high through the first five rising edges

module tbClock (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;  // Released just after the edge, like the other inputs
  end

endmodule

// File: verification/cacheFsm_sva.sv
// Protocol assertions for the cache controller
// Bound into every cacheFsm instance, watches bus strobes and the CPU stall

module cacheFsm_sva (
  input logic       clk,
  input logic       rst,
  input logic [1:0] cacheRW,
  input logic [1:0] busRW,
  input logic       flushCache,
  input logic       invalidateCache,
  input logic       hit,
  input logic       busAck,
  input logic       stall,
  input logic [2:0] state
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [2:0] READY = 3'd0;  // First state of the controller enum

  int unsigned failCount = 0;           // Read back by the testbench at the end

  // Fetch and writeback never requested together
  strobesExclusive: assert property (@(posedge clk) disable iff (rst)
    !(busRW[1] && busRW[0]))
    else begin
      failCount++;
      $error("Line fetch and line writeback requested in the same cycle");
    end

  // Line done only for a running request
  ackWithStrobe: assert property (@(posedge clk) disable iff (rst)
    busAck |-> (busRW != 2'b00))
    else begin
      failCount++;
      $error("busAck arrived with no bus strobe set");
    end

  // Idle or hitting CPU is never held in ready
  noStallOnHit: assert property (@(posedge clk) disable iff (rst)
    (state == READY && !flushCache && !invalidateCache && (cacheRW == 2'b00 || hit))
      |-> !stall)
    else begin
      failCount++;
      $error("stall high in ready without a miss, flush or invalidate");
    end

endmodule

bind cacheFsm cacheFsm_sva u_sva (
  .clk, .rst, .cacheRW, .busRW, .flushCache, .invalidateCache, .hit, .busAck, .stall,
  .state(state)
);

// File: verification/cacheTb.sv
// Testbench for the write-back cache with a random-latency memory model and a shadow model
// Applies the operation table in order and checks data and beat counts after each operation

module cacheTb import cachePkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD  = 100;
  localparam int          MEM_WORDS   = 65536;
  localparam logic [31:0] SEED        = 32'h25f491fe;
  localparam int          NUM_OPS     = 22;
  localparam int          WATCHDOG_NS = (NUM_OPS * 200 + 10) * CLK_PERIOD;

  typedef enum logic [2:0] {opRead, opWrite, opFlush, opInv, opPoke, opMemChk} opKindT;

  typedef struct packed {
    opKindT      kind;
    logic [15:0] adr;
    logic [31:0] data;
    logic [7:0]  expWr;   // Memory write beats expected
    logic [7:0]  expRd;   // Memory read beats expected
  } opT;

  // Address is tag[15:6], set[5:2], offset[1:0]
  opT ops [NUM_OPS] = '{
    '{opRead,   16'h0040, 32'h0,        8'd0,  8'd4},  // Cold miss in set 0
    '{opRead,   16'h0043, 32'h0,        8'd0,  8'd0},  // Same line, no memory traffic
    '{opWrite,  16'h0041, 32'hdeadbeef, 8'd0,  8'd0},  // Store hit
    '{opRead,   16'h0041, 32'h0,        8'd0,  8'd0},
    '{opWrite,  16'h0042, 32'h12345678, 8'd0,  8'd0},
    '{opRead,   16'h0080, 32'h0,        8'd4,  8'd4},  // Conflict with a dirty victim
    '{opMemChk, 16'h0041, 32'h0,        8'd0,  8'd0},
    '{opMemChk, 16'h0042, 32'h0,        8'd0,  8'd0},
    '{opWrite,  16'h0084, 32'ha1a1a1a1, 8'd0,  8'd4},  // Write misses in sets 1 to 3
    '{opWrite,  16'h0089, 32'ha2a2a2a2, 8'd0,  8'd4},
    '{opWrite,  16'h00cf, 32'ha3a3a3a3, 8'd0,  8'd4},
    '{opWrite,  16'h0081, 32'ha0a0a0a0, 8'd0,  8'd0},
    '{opFlush,  16'h0000, 32'h0,        8'd16, 8'd0},  // Four dirty sets
    '{opRead,   16'h0089, 32'h0,        8'd0,  8'd0},
    '{opMemChk, 16'h00cf, 32'h0,        8'd0,  8'd0},
    '{opWrite,  16'h0300, 32'h5555aaaa, 8'd0,  8'd4},
    '{opFlush,  16'h0000, 32'h0,        8'd4,  8'd0},
    '{opPoke,   16'h0300, 32'h0badf00d, 8'd0,  8'd0},  // Cached copy now stale
    '{opInv,    16'h0000, 32'h0,        8'd0,  8'd0},
    '{opRead,   16'h0300, 32'h0,        8'd0,  8'd4},
    '{opRead,   16'h0084, 32'h0,        8'd0,  8'd4},  // Flushed data back from memory
    '{opRead,   16'h0301, 32'h0,        8'd0,  8'd0}
  };

  logic        clk, rst;
  logic [1:0]  cacheRW;
  cacheAdrT    adr;
  logic [31:0] writeData, readData, memWriteData;
  logic        flushCache, invalidateCache, stall, memRead, memWrite;
  logic [15:0] memAdr;
  logic [31:0] memReadData = '0;
  logic        memAck      = 1'b0;

  // Memory model state
  logic [31:0] mem    [MEM_WORDS];
  logic [31:0] shadow [MEM_WORDS];  // Expected contents as the CPU sees them
  logic [31:0] lcgState = SEED;
  logic [31:0] dataNext = '0;
  logic        ackNext  = 1'b0;
  logic        counting = 1'b0;
  int          waitLeft = 0;
  int          wrBeats  = 0;
  int          rdBeats  = 0;

  tbClock u_clk (.clk, .rst);

  cacheTop u_dut (.*);

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fillWord(input logic [15:0] a);
    return {a ^ 16'hc3a5, ~a};  // Every address bit shows up
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  // Decide at the falling edge, drive memAck for one cycle after the next rising edge
  always begin
    @(negedge clk);
    ackNext = 1'b0;
    if (!rst && (memRead || memWrite) && !memAck) begin
      if (!counting) begin
        lcgState = lcgNext(lcgState);
        waitLeft = 1 + int'(lcgState[17:16]);  // 1 to 4 cycles
        counting = 1'b1;
      end
      waitLeft--;
      if (waitLeft == 0) begin
        counting = 1'b0;
        ackNext  = 1'b1;
        if (memWrite) begin
          mem[memAdr] = memWriteData;
          wrBeats++;
        end else begin
          dataNext = mem[memAdr];
          rdBeats++;
        end
      end
    end
    @(posedge clk);
    #1;
    memAck      = ackNext;
    memReadData = dataNext;
  end

  ////////////////////
  // CPU side
  ////////////////////

  task automatic waitNoStall();
    do @(negedge clk); while (stall);
  endtask

  task automatic access(input logic [1:0] rw, input logic [15:0] a, input logic [31:0] d,
                        output logic [31:0] rdata);
    cacheRW   = rw;
    adr.word  = a;
    writeData = d;
    waitNoStall();
    rdata = readData;     // Stable mid-cycle
    @(posedge clk);
    #1;
    cacheRW = 2'b00;
  endtask

  task automatic flush();
    flushCache = 1'b1;
    waitNoStall();
    @(posedge clk);
    #1;
    flushCache = 1'b0;
  endtask

  task automatic pulseInvalidate();
    invalidateCache = 1'b1;
    @(posedge clk);
    #1;
    invalidateCache = 1'b0;
  endtask

  task automatic compareMemory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (mem[i] !== shadow[i]) check($sformatf("memory at %h after flush", i), mem[i], shadow[i]);
    end
  endtask

  task automatic runOp(input opT op);
    logic [31:0] got;
    wrBeats = 0;
    rdBeats = 0;
    case (op.kind)
      opRead: begin
        access(2'b10, op.adr, 32'h0, got);
        check($sformatf("read data at %h", op.adr), got, shadow[op.adr]);
      end
      opWrite: begin
        access(2'b01, op.adr, op.data, got);
        shadow[op.adr] = op.data;
      end
      opFlush: begin
        flush();
        compareMemory();  // Nothing dirty is left behind
      end
      opInv:    pulseInvalidate();
      opPoke: begin
        mem[op.adr]    = op.data;
        shadow[op.adr] = op.data;  // Seen by the CPU after an invalidate
      end
      opMemChk: check($sformatf("memory word at %h", op.adr), mem[op.adr], shadow[op.adr]);
      default: ;
    endcase
    check("memory write beats", 32'(wrBeats), 32'(op.expWr));
    check("memory read beats", 32'(rdBeats), 32'(op.expRd));
  endtask

  initial begin
    cacheRW         = 2'b00;
    adr             = '0;
    writeData       = '0;
    flushCache      = 1'b0;
    invalidateCache = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = fillWord(16'(i));
      shadow[i] = mem[i];
    end
    wait (rst === 1'b0);
    @(negedge clk);
    check("stall after reset", 32'(stall), 32'd0);     // Idle with nothing requested
    check("memRead after reset", 32'(memRead), 32'd0);
    check("memWrite after reset", 32'(memWrite), 32'd0);
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_OPS; i++) runOp(ops[i]);
    check("assertion failures", u_dut.u_fsm.u_sva.failCount, 32'd0);
    $display("Everything OK");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout, the operation table did not finish in time");
    $display("Something failed");
    $fatal(1, "Timeout");
  end

endmodule

// File: build.f
hw/cachePkg.sv
hw/cacheFsm.sv
hw/tagArray.sv
hw/dataArray.sv
hw/lineBus.sv
hw/cacheTop.sv
verification/tbClock.sv
verification/cacheFsm_sva.sv
verification/cacheTb.sv

// File: Makefile
# Verilator build and run of the cache testbench
# Override any variable on the command line, e.g. make OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
